// File: include/hazardModel.svh
`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

// Shadow records, index 0 is ID, then EX, MEM and WB
regAddrT  shRd     [StageNum];
logic     shWrites [StageNum];
logic     shMem    [StageNum];
dataWordT shAddr   [StageNum];
logic     shJumped;             // Jump bubble already spent

// Expected outputs for the cycle under check
logic   expNop;
logic   expStall;
fwdSelT expFwd;

// Empty pipeline, as after reset
task automatic clearModel();
    for (int s = 0; s < StageNum; s++) begin
        shRd[s]     = '0;
        shWrites[s] = 1'b0;
        shMem[s]    = 1'b0;
        shAddr[s]   = '0;
    end
    shJumped = 1'b0;
endtask

function automatic logic isJumpOp(input dataWordT ins);
    return (ins[15:11] == opJ) || (ins[15:11] == opJal);  // Branches 011xx excluded
endfunction

// Hazard rules applied to the inputs in force this cycle
task automatic predict(input dataWordT ins, input logic memEn, input dataWordT base,
                       input dataWordT ofs, input logic taken);
    logic [StageNum-1:0] hitS;
    logic [StageNum-1:0] hitT;
    logic [StageNum-1:0] hitM;
    logic                useRt;
    logic                live;
    dataWordT            addr;
    useRt = (ins[15:11] != opJr) && (ins[15:11] != opJalr);  // JR and JALR read no Rt
    addr  = base + ofs;
    for (int s = 0; s < StageNum; s++) begin
        live    = !((s == 0) && taken);  // Taken branch cancels the ID record
        hitS[s] = live && shWrites[s] && (shRd[s] == ins[10:8]);
        hitT[s] = live && shWrites[s] && (shRd[s] == ins[7:5]);
        hitM[s] = live && shMem[s] && memEn && (shAddr[s] == addr);
    end
    expNop   = (|hitS) || (useRt && (|hitT)) || (|hitM);
    expStall = expNop || (isJumpOp(ins) && !shJumped);
    // EX-to-EX from ID, MEM-to-EX from EX
    expFwd   = {hitS[0], hitS[1], useRt && hitT[0], useRt && hitT[1]};
endtask

// Pipeline step at the rising edge
task automatic advance(input dataWordT ins, input regAddrT rdIn, input logic wrIn,
                       input logic memEn, input dataWordT base, input dataWordT ofs,
                       input logic taken);
    logic link;
    link = (ins[15:11] == opJal);
    for (int s = StageNum - 1; s > 1; s--) begin
        shRd[s]     = shRd[s-1];
        shWrites[s] = shWrites[s-1];
        shMem[s]    = shMem[s-1];
        shAddr[s]   = shAddr[s-1];
    end
    // Record entering EX is empty after a taken branch
    shRd[1]     = shRd[0];
    shWrites[1] = shWrites[0] && !taken;
    shMem[1]    = shMem[0] && !taken;
    shAddr[1]   = shAddr[0];
    shJumped    = isJumpOp(ins) && !shJumped && !expNop;
    if (expNop) begin
        shWrites[0] = 1'b0;               // Bubble into ID
        shMem[0]    = 1'b0;
    end else begin
        shRd[0]     = link ? linkReg : rdIn;  // JAL links to r7
        shWrites[0] = wrIn || link;
        shMem[0]    = memEn;
        shAddr[0]   = base + ofs;
    end
endtask

`endif

// File: bench/hazardBench.sv
`timescale 1ns/10ps

module hazardBench import hazardPkg::*; ();

    localparam int Period    = 100;
    localparam int HoldLimit = 16;   // Worst legal stall is a few cycles
    localparam int RegRounds = 300;
    localparam int MemRounds = 300;
    localparam int Seed      = 33241;

    logic     clk;
    logic     reset;
    dataWordT instr;
    regAddrT  rd;
    logic     writes;
    logic     memEnable;
    dataWordT reg1Data;
    dataWordT imm;
    logic     branchTaken;
    logic     nop;
    logic     pcStall;
    fwdSelT   forwards;

    // Instruction being issued and its side inputs
    dataWordT nextInstr;
    regAddrT  nextRd;
    logic     nextWrites;
    logic     nextMem;
    dataWordT nextBase;
    dataWordT nextImm;

    logic seenNop;     // Outputs as sampled this cycle
    logic seenStall;
    logic hung;        // Stall never released, stop issuing
    int   errors;
    int   checks;

    `include "hazardModel.svh"

    hazardTop i_hazardTop (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .rd          (rd),
        .writes      (writes),
        .memEnable   (memEnable),
        .reg1Data    (reg1Data),
        .imm         (imm),
        .branchTaken (branchTaken),
        .nop         (nop),
        .pcStall     (pcStall),
        .forwards    (forwards)
    );

    initial begin
        clk = 1'b0;
        forever #(Period/2) clk = ~clk;
    end

    task automatic reportAndStop();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic compareOutputs();
        checks++;
        if (nop !== expNop) begin
            $display("FAILED nop: got %h, expected %h", nop, expNop);
            errors++;
        end
        if (pcStall !== expStall) begin
            $display("FAILED pcStall: got %h, expected %h", pcStall, expStall);
            errors++;
        end
        if (forwards !== expFwd) begin
            $display("FAILED forwards: got %h, expected %h", forwards, expFwd);
            errors++;
        end
    endtask

    // Mostly r0 and r1 so matches are frequent, r7 now and then for JAL
    function automatic regAddrT pickReg();
        if ($urandom_range(3) == 0) return linkReg;
        return regAddrT'($urandom_range(1));
    endfunction

    task automatic buildInstr(input logic memMode);
        opcodeT  op;
        regAddrT srcS;
        regAddrT srcT;
        case ($urandom_range(7))
            0: op = opJ;
            1: op = opJal;
            2: op = opJr;
            3: op = opJalr;
            4: op = opNop;
            5: op = {opBranchTop, 2'($urandom_range(3))};
            default: op = opcodeT'($urandom_range(31));
        endcase
        srcS       = pickReg();
        srcT       = pickReg();
        nextRd     = pickReg();
        nextWrites = ($urandom_range(2) != 0);
        nextMem    = memMode && ($urandom_range(3) != 0);
        nextBase   = memMode ? dataWordT'($urandom_range(3)) : dataWordT'($urandom);
        nextImm    = memMode ? dataWordT'($urandom_range(2)) : dataWordT'($urandom);
        if ((op == opJ) || (op == opJal)) begin
            // A held jump would otherwise match the record it just left in ID
            srcS       = regAddrT'($urandom_range(1));
            srcT       = regAddrT'($urandom_range(1));
            nextWrites = 1'b0;
            nextMem    = 1'b0;
        end
        nextInstr = {op, srcS, srcT, 5'($urandom_range(31))};
    endtask

    // One cycle, drive on falling edge and check before the rising edge
    task automatic runCycle();
        @(negedge clk);
        instr       = nextInstr;
        rd          = nextRd;
        writes      = nextWrites;
        memEnable   = nextMem;
        reg1Data    = nextBase;
        imm         = nextImm;
        branchTaken = ($urandom_range(3) == 0);
        predict(nextInstr, nextMem, nextBase, nextImm, branchTaken);
        #(Period/4);
        compareOutputs();
        seenNop   = nop;
        seenStall = pcStall;
        @(posedge clk);
        advance(nextInstr, nextRd, nextWrites, nextMem, nextBase, nextImm, branchTaken);
    endtask

    // Issue one instruction and hold it while fetch is stalled
    task automatic issue();
        int held;
        int jumpStalls;
        held       = 0;
        jumpStalls = 0;
        runCycle();
        if (seenStall && !seenNop) jumpStalls++;
        while ((seenStall === 1'b1) && !hung) begin
            held++;
            if (held > HoldLimit) begin
                $display("Instruction held for %0d cycles and pcStall never dropped", held);
                errors++;
                hung = 1'b1;
            end else begin
                runCycle();
                if (seenStall && !seenNop) jumpStalls++;
            end
        end
        if (!hung && isJumpOp(nextInstr) && (jumpStalls != 1)) begin
            $display("Jump stalled fetch for %0d cycles instead of one", jumpStalls);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(Seed));  // One seed for the whole run
        errors      = 0;
        checks      = 0;
        hung        = 1'b0;
        reset       = 1'b1;
        instr       = '0;
        rd          = '0;
        writes      = 1'b0;
        memEnable   = 1'b0;
        reg1Data    = '0;
        imm         = '0;
        branchTaken = 1'b0;
        seenNop     = 1'b0;
        seenStall   = 1'b0;
        clearModel();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Empty pipeline right after reset
        buildInstr(1'b0);
        nextInstr[15:11] = opNop;
        runCycle();
        if (seenNop || seenStall) begin
            $display("Stall or bubble raised for the first instruction after reset");
            errors++;
        end

        repeat (RegRounds) begin  // Register RAW, forwarding, JR/JALR, JAL link
            if (!hung) begin
                buildInstr(1'b0);
                issue();
            end
        end
        repeat (MemRounds) begin  // Memory RAW from a small address set
            if (!hung) begin
                buildInstr(1'b1);
                issue();
            end
        end
        reportAndStop();
    end

endmodule

// File: list.f
+incdir+include
logic/hazardPkg.sv
logic/slotBus.sv
logic/instrDecoder.sv
logic/stageSlot.sv
logic/hazardCombiner.sv
logic/hazardTop.sv
bench/hazardBench.sv

// File: logic/hazardCombiner.sv
`timescale 1ns/10ps

// Merges per-slot matches into stall, bubble and forward selects
module hazardCombiner import hazardPkg::*; #(
    parameter int StageCount = StageNum
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [StageCount-1:0] rsHit,    // One bit per tracked stage
    input  logic [StageCount-1:0] rtHit,
    input  logic [StageCount-1:0] memHit,
    input  logic                  checkRt,
    input  logic                  isJump,
    output logic                  nop,
    output logic                  pcStall,
    output fwdSelT                forwards
);

    logic regHazard;
    logic memHazard;
    logic jumpFlag;     // Jump bubble already taken
    logic jumpStall;

    // Rt matches do not count for JR and JALR
    assign regHazard = (|rsHit) || (checkRt && (|rtHit));
    assign memHazard = |memHit;

    assign nop = regHazard || memHazard;

    // One stall cycle per jump, then let the target through
    assign jumpStall = isJump && !jumpFlag;
    assign pcStall   = nop || jumpStall;

    // Flag only when the jump itself caused the stall
    always_ff @(posedge clk) begin
        if (reset) begin
            jumpFlag <= 1'b0;
        end else begin
            jumpFlag <= jumpStall && !nop;
        end
    end

    // EX-to-EX from the ID record, MEM-to-EX from the EX record
    assign forwards[3] = rsHit[SlotId];
    assign forwards[2] = rsHit[SlotEx];
    assign forwards[1] = rtHit[SlotId] && checkRt;
    assign forwards[0] = rtHit[SlotEx] && checkRt;

    // Fetch holds the instruction while stalled, so its class cannot change
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (reset) pcStall |=> $stable({isJump, checkRt})
    ) else $error("hazardCombiner: instruction changed during a stall");

endmodule

// File: logic/hazardPkg.sv
// Shared widths, types and opcodes for the hazard detection unit
package hazardPkg;

    // Default widths, top level passes them down as parameters
    localparam int WordWidth = 16;   // Data and address word
    localparam int RegWidth  = 3;    // Eight registers
    localparam int OpWidth   = 5;    // Opcode in the top bits
    localparam int StageNum  = 4;    // ID, EX, MEM and WB records

    // Slot index of each tracked stage
    localparam int SlotId  = 0;
    localparam int SlotEx  = 1;
    localparam int SlotMem = 2;
    localparam int SlotWb  = 3;

    typedef logic [WordWidth-1:0] dataWordT;  // Data or address
    typedef logic [RegWidth-1:0]  regAddrT;   // Register index
    typedef logic [OpWidth-1:0]   opcodeT;    // instr[15:11]

    // Forward selects, MSB first
    // EX-to-EX Rs, MEM-to-EX Rs, EX-to-EX Rt, MEM-to-EX Rt
    typedef logic [3:0] fwdSelT;

    // Opcodes the unit cares about
    localparam opcodeT opNop  = 5'b00001;
    localparam opcodeT opJ    = 5'b00100;
    localparam opcodeT opJr   = 5'b00101;
    localparam opcodeT opJal  = 5'b00110;
    localparam opcodeT opJalr = 5'b00111;

    // Branch group is 011xx, only the top three bits are compared
    localparam logic [2:0] opBranchTop = 3'b011;

    // JAL writes its return address here
    localparam regAddrT linkReg = 3'd7;

endpackage

// File: logic/hazardTop.sv
`timescale 1ns/10ps

// Hazard detection unit for the five-stage pipeline
module hazardTop import hazardPkg::*; #(
    parameter int DataWidth    = WordWidth,
    parameter int RegAddrWidth = RegWidth,
    parameter int StageCount   = StageNum  // ID, EX, MEM, WB
) (
    input  logic     clk,
    input  logic     reset,
    input  dataWordT instr,        // Instruction in fetch/decode
    input  regAddrT  rd,
    input  logic     writes,
    input  logic     memEnable,
    input  dataWordT reg1Data,
    input  dataWordT imm,
    input  logic     branchTaken,  // From execute
    output logic     nop,
    output logic     pcStall,
    output fwdSelT   forwards
);

    regAddrT               rs;
    regAddrT               rt;
    logic                  checkRt;
    logic                  isJump;
    logic [StageCount-1:0] rsHit;
    logic [StageCount-1:0] rtHit;
    logic [StageCount-1:0] memHit;

    // Link 0 feeds the ID slot, link i+1 leaves slot i
    slotBus links [StageCount+1] ();

    instrDecoder #(
        .DataWidth    (DataWidth),
        .RegAddrWidth (RegAddrWidth)
    ) i_instrDecoder (
        .instr     (instr),
        .rd        (rd),
        .writes    (writes),
        .memEnable (memEnable),
        .reg1Data  (reg1Data),
        .imm       (imm),
        .rs        (rs),
        .rt        (rt),
        .checkRt   (checkRt),
        .isJump    (isJump),
        .record    (links[0])
    );

    for (genvar i = 0; i < StageCount; i++) begin : g_slot
        stageSlot #(
            .Flushable (i == 0)     // Only the ID record can be cancelled
        ) i_stageSlot (
            .clk          (clk),
            .reset        (reset),
            .bubble       ((i == 0) ? nop : 1'b0),  // Stall drops a bubble into ID
            .flush        (branchTaken),
            .rs           (rs),
            .rt           (rt),
            .memAddrNow   (links[0].memAddr),
            .memEnableNow (memEnable),
            .prev         (links[i]),
            .next         (links[i+1]),
            .rsHit        (rsHit[i]),
            .rtHit        (rtHit[i]),
            .memHit       (memHit[i])
        );
    end

    hazardCombiner #(
        .StageCount (StageCount)
    ) i_hazardCombiner (
        .clk      (clk),
        .reset    (reset),
        .rsHit    (rsHit),
        .rtHit    (rtHit),
        .memHit   (memHit),
        .checkRt  (checkRt),
        .isJump   (isJump),
        .nop      (nop),
        .pcStall  (pcStall),
        .forwards (forwards)
    );

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/10ps

// Decodes the instruction in fetch/decode into the fields the unit tracks
module instrDecoder import hazardPkg::*; #(
    parameter int DataWidth    = WordWidth,
    parameter int RegAddrWidth = RegWidth
) (
    input  dataWordT     instr,
    input  regAddrT      rd,         // Destination from the decode logic
    input  logic         writes,
    input  logic         memEnable,
    input  dataWordT     reg1Data,   // Base register value
    input  dataWordT     imm,
    output regAddrT      rs,
    output regAddrT      rt,
    output logic         checkRt,    // Low for JR and JALR
    output logic         isJump,     // J or JAL
    slotBus.source       record      // Into slot 0
);

    // Field positions counted down from the top of the word
    localparam int OpTop = DataWidth - 1;
    localparam int RsTop = DataWidth - OpWidth - 1;
    localparam int RtTop = RsTop - RegAddrWidth;

    opcodeT opcode;
    logic   link;     // JAL only

    assign opcode = instr[OpTop -: OpWidth];
    assign rs     = instr[RsTop -: RegAddrWidth];  // Bits 10 to 8
    assign rt     = instr[RtTop -: RegAddrWidth];  // Bits 7 to 5

    always_comb begin
        isJump  = 1'b0;
        link    = 1'b0;
        checkRt = 1'b1;
        case (opcode)
            opJ: begin
                isJump = 1'b1;
            end
            opJal: begin
                isJump = 1'b1;
                link   = 1'b1;  // Return address to r7
            end
            opJr, opJalr: begin
                checkRt = 1'b0;  // Rt field is not a source here
            end
            default: begin
                // Branches 011xx resolve in EX, no fetch bubble for them
            end
        endcase
    end

    // True destination, JAL forces the link write
    assign record.rd        = link ? linkReg : rd;
    assign record.writes    = writes | link;
    assign record.memEnable = memEnable;
    assign record.memAddr   = reg1Data + imm;  // Effective address

endmodule

// File: logic/slotBus.sv
`timescale 1ns/10ps

// One shadow record passed from slot to slot
interface slotBus import hazardPkg::*; ();

    regAddrT  rd;         // Destination register
    logic     writes;     // Record writes rd
    logic     memEnable;  // Record touches memory
    dataWordT memAddr;    // Base plus immediate

    // Producer of the record, decoder or previous slot
    modport source (
        output rd,
        output writes,
        output memEnable,
        output memAddr
    );

    // Consumer, the next slot
    modport sink (
        input rd,
        input writes,
        input memEnable,
        input memAddr
    );

endinterface

// File: logic/stageSlot.sv
`timescale 1ns/10ps

// Shadow record of one pipeline stage plus its hazard comparators
module stageSlot import hazardPkg::*; #(
    parameter bit Flushable = 1'b0  // Set for the ID slot only
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     bubble,        // Load an empty record
    input  logic     flush,         // Taken branch
    input  regAddrT  rs,            // Sources of the current instruction
    input  regAddrT  rt,
    input  dataWordT memAddrNow,    // Address of the current access
    input  logic     memEnableNow,
    slotBus.sink     prev,
    slotBus.source   next,
    output logic     rsHit,
    output logic     rtHit,
    output logic     memHit
);

    regAddrT  rdQ;
    logic     writesQ;
    logic     memEnableQ;
    dataWordT memAddrQ;
    logic     killed;   // Record cancelled by a taken branch

    // Control bits clear on reset and on a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            writesQ    <= 1'b0;
            memEnableQ <= 1'b0;
        end else if (bubble) begin
            writesQ    <= 1'b0;
            memEnableQ <= 1'b0;
        end else begin
            writesQ    <= prev.writes;
            memEnableQ <= prev.memEnable;
        end
    end

    // Payload only matters while a control bit is set
    always_ff @(posedge clk) begin
        rdQ      <= prev.rd;
        memAddrQ <= prev.memAddr;
    end

    assign killed = Flushable && flush;

    // Register RAW, this record writes a source of the current instruction
    assign rsHit = writesQ && (rdQ == rs) && !killed;
    assign rtHit = writesQ && (rdQ == rt) && !killed;

    // Memory RAW, both access the same address
    assign memHit = memEnableQ && memEnableNow && (memAddrQ == memAddrNow) && !killed;

    // Record moves on, empty if cancelled
    assign next.rd        = rdQ;
    assign next.writes    = writesQ && !killed;
    assign next.memEnable = memEnableQ && !killed;
    assign next.memAddr   = memAddrQ;

    // A bubble means fetch is frozen, so the sources it compares stay put
    sourcesHeld: assert property (
        @(posedge clk) disable iff (reset) bubble |=> ($stable(rs) && $stable(rt))
    ) else $error("stageSlot: sources changed while a bubble was inserted");

endmodule

// File: run.sh
#!/bin/sh
# Builds the hazard unit testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module hazardBench -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VhazardBench)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
